//--- sim.f
src/board_pkg.sv
src/regmap_pkg.sv
src/spi_reg_slave.sv
src/reg_bank.sv
src/rx_err_counters.sv
src/led_heartbeat.sv
src/board_ctrl_top.sv
sim/tb_clk_gen.sv
sim/tb_board_ctrl.sv

//--- Makefile
# Verilator build and run of the board control testbench
# make run builds if needed, runs, and fails unless the log shows a pass

VERILATOR ?= verilator
TOP       ?= tb_board_ctrl
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

FILELIST  := sim.f
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_board_ctrl.sv
// testbench for the board control top covering SPI register access, PHY pins, flash path and LED
// a register model predicts every read and a compare process checks them
`timescale 1ns/1ps

module tb_board_ctrl;
    import regmap_pkg::*;

    localparam int          ETH_COUNT  = 4;
    localparam int          CLK_PER_US = 4;
    localparam int          US_PER_MS  = 5;
    localparam int          BLINK_MS   = 3;
    localparam logic [31:0] FW_DATE    = 32'h3141_5926;
    localparam logic [31:0] FW_TIME    = 32'h2718_2818;
    localparam int HALF        = 8;                 // SCLK half period in clocks
    localparam int FRAME_CYC   = 52 * HALF + 1;     // 24 bits plus CS setup and gap
    localparam int N_FRAMES    = 150;               // rough frame count of all tests
    localparam int WATCHDOG_NS = 2 * N_FRAMES * FRAME_CYC * 8;
    localparam int LED_PERIOD  = CLK_PER_US * US_PER_MS * BLINK_MS;

    logic                 clk125M, rst_n;
    logic                 spi_sclk, spi_mosi, qspi_miso;
    logic [1:0]           spi_cs;
    logic [ETH_COUNT-1:0] eth_link, eth_crc_err, eth_phy_rst;
    logic                 tb_mdio_en, tb_mdio_val;  // PHY side of the MDIO pin
    wire                  mdio_pin;
    logic                 usr_spi_miso, qspi_cs, qspi_mosi, eth_phy_mdc, dbg_led;

    // ------------------------------
    // register model
    // ------------------------------
    logic [ETH_COUNT-1:0] m_phy_rst, m_link;
    logic                 m_mdc, m_mdio_o, m_mdio_oe, m_tb_mdio;
    logic [15:0]          m_test [TEST_WORDS];
    logic [31:0]          m_err_cnt [ETH_COUNT];

    logic [15:0] lfsr_q;
    logic [6:0]  rd_addr_q [$];
    logic [15:0] rd_data_q [$];
    event        rd_done;
    int          n_checks, n_errors;

    assign mdio_pin = tb_mdio_en ? tb_mdio_val : 1'bz;

    tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(8)) u_clk (.clk_o(clk125M), .rst_n_o(rst_n));

    board_ctrl_top #(
        .ETH_COUNT (ETH_COUNT), .CLK_PER_US (CLK_PER_US), .US_PER_MS (US_PER_MS),
        .BLINK_MS  (BLINK_MS),  .FW_DATE    (FW_DATE),    .FW_TIME   (FW_TIME)
    ) DUT (
        .clk125M        (clk125M),     .rst_n_i        (rst_n),
        .usr_spi_clk_i  (spi_sclk),    .usr_spi_cs_i   (spi_cs),
        .usr_spi_mosi_i (spi_mosi),    .usr_spi_miso_o (usr_spi_miso),
        .qspi_cs_o      (qspi_cs),     .qspi_mosi_o    (qspi_mosi),
        .qspi_miso_i    (qspi_miso),   .eth_link_i     (eth_link),
        .eth_crc_err_i  (eth_crc_err), .eth_phy_rst_o  (eth_phy_rst),
        .eth_phy_mdc_o  (eth_phy_mdc), .eth_phy_mdio   (mdio_pin),
        .dbg_led_o      (dbg_led)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};  // one step per bit
        end
        return r;
    endfunction

    function automatic void model_write(input logic [6:0] a, input logic [15:0] d);
        case (a)
            A_PHY_RST: m_phy_rst = d[ETH_COUNT-1:0];
            A_MDC:     m_mdc     = d[0];
            A_MDIO_O:  m_mdio_o  = d[0];
            A_MDIO_OE: m_mdio_oe = d[0];
            default: begin
                if (a >= A_TEST_BASE && a < A_TEST_BASE + 7'(TEST_WORDS)) begin
                    m_test[a - A_TEST_BASE] = d;
                end
            end
        endcase
    endfunction

    // expected read value of any address
    function automatic logic [15:0] ref_reg(input logic [6:0] a);
        int idx;
        case (a)
            A_FW_DATE_LO: return FW_DATE[15:0];
            A_FW_DATE_HI: return FW_DATE[31:16];
            A_FW_TIME_LO: return FW_TIME[15:0];
            A_FW_TIME_HI: return FW_TIME[31:16];
            A_LINK:       return 16'(m_link);
            A_PHY_RST:    return 16'(m_phy_rst);
            A_MDC:        return 16'(m_mdc);
            A_MDIO_O:     return 16'(m_mdio_o);
            A_MDIO_OE:    return 16'(m_mdio_oe);
            A_MDIO_I:     return 16'(m_mdio_oe ? m_mdio_o : m_tb_mdio);
            default: begin
                if (a >= A_RXERR_BASE && a < A_RXERR_BASE + 7'(2 * ETH_COUNT)) begin
                    idx = int'(a - A_RXERR_BASE);
                    return idx[0] ? m_err_cnt[idx / 2][31:16] : m_err_cnt[idx / 2][15:0];
                end
                if (a >= A_TEST_BASE && a < A_TEST_BASE + 7'(TEST_WORDS)) begin
                    return m_test[a - A_TEST_BASE];
                end
                return 16'h0000;
            end
        endcase
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk125M);
    endtask

    // ------------------------------
    // SPI master in mode 0
    // ------------------------------
    task automatic spi_frame(input logic [23:0] tx, output logic [15:0] rx);
        rx = '0;
        spi_cs <= 2'b01;                        // register slave selected
        wait_cycles(HALF);
        for (int i = 23; i >= 0; i--) begin
            spi_mosi <= tx[i];
            wait_cycles(HALF);
            if (i < 16) rx[i] = usr_spi_miso;   // sampled at the rise
            spi_sclk <= 1'b1;
            wait_cycles(HALF);
            spi_sclk <= 1'b0;
        end
        wait_cycles(HALF);
        spi_cs <= 2'b11;
        wait_cycles(2 * HALF);
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [15:0] data);
        logic [15:0] rx_ignored;
        spi_frame({1'b1, addr, data}, rx_ignored);
        model_write(addr, data);
    endtask

    task automatic spi_read(input logic [6:0] addr);
        logic [15:0] rx;
        spi_frame({1'b0, addr, 16'h0000}, rx);
        rd_addr_q.push_back(addr);
        rd_data_q.push_back(rx);
        -> rd_done;
        @(posedge clk125M);     // compare runs before the model moves on
    endtask

    task automatic read_all();
        for (int a = 0; a < 'h28; a++) spi_read(7'(a));
    endtask

    task automatic check_pins();
        check_eq("eth_phy_rst_o", 32'(eth_phy_rst), 32'(m_phy_rst));
        check_eq("eth_phy_mdc_o", 32'(eth_phy_mdc), 32'(m_mdc));
        if (m_mdio_oe) check_eq("eth_phy_mdio", 32'(mdio_pin), 32'(m_mdio_o));
    endtask

    task automatic check_flash_path();
        logic miso_v, mosi_v;
        spi_cs <= 2'b10;        // flash selected with the register slave idle
        for (int i = 0; i < 16; i++) begin
            miso_v = 1'(rand_bits(1));
            mosi_v = 1'(rand_bits(1));
            qspi_miso <= miso_v;
            spi_mosi  <= mosi_v;
            @(posedge clk125M);
            check_eq("usr_spi_miso_o", 32'(usr_spi_miso), 32'(miso_v));
            check_eq("qspi_mosi_o", 32'(qspi_mosi), 32'(mosi_v));
            check_eq("qspi_cs_o", 32'(qspi_cs), 32'd0);
        end
        spi_cs <= 2'b11;
        @(posedge clk125M);
        check_eq("qspi_cs_o", 32'(qspi_cs), 32'd1);
    endtask

    task automatic check_led();
        logic prev;
        int   cnt, last, edges;
        prev  = dbg_led;
        cnt   = 0;
        last  = 0;
        edges = 0;
        while (edges < 3 && cnt < 4 * LED_PERIOD) begin
            @(posedge clk125M);
            cnt++;
            if (dbg_led !== prev) begin
                if (edges > 0) check_eq("LED edge spacing", 32'(cnt - last), 32'(LED_PERIOD));
                last = cnt;
                prev = dbg_led;
                edges++;
            end
        end
        assert (edges == 3) else begin
            n_errors++;
            $display("LED stopped toggling, only %0d edges in %0d cycles", edges, cnt);
        end
    endtask

    // ------------------------------
    // compare and watchdog
    // ------------------------------
    initial begin : compare_reads
        logic [6:0]  a;
        logic [15:0] d;
        forever begin
            @(rd_done);
            while (rd_addr_q.size() > 0) begin
                a = rd_addr_q.pop_front();
                d = rd_data_q.pop_front();
                check_eq($sformatf("register 0x%02h", a), 32'(d), 32'(ref_reg(a)));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        int n [ETH_COUNT];
        logic [ETH_COUNT-1:0] v;
        spi_sclk    = 1'b0;
        spi_mosi    = 1'b0;
        spi_cs      = 2'b11;
        qspi_miso   = 1'b0;     // flash term must stay masked by its CS
        eth_link    = '0;
        eth_crc_err = '0;
        tb_mdio_en  = 1'b1;     // PHY holds the pin low while idle
        tb_mdio_val = 1'b0;
        lfsr_q      = 16'd71;
        n_checks    = 0;
        n_errors    = 0;
        {m_phy_rst, m_link, m_mdc, m_mdio_o, m_mdio_oe, m_tb_mdio} = '0;
        for (int i = 0; i < TEST_WORDS; i++) m_test[i] = '0;
        for (int p = 0; p < ETH_COUNT; p++) m_err_cnt[p] = '0;
        wait (rst_n === 1'b1);
        wait_cycles(4);

        read_all();             // reset values and firmware stamp
        for (int i = 0; i < TEST_WORDS; i++) spi_write(A_TEST_BASE + 7'(i), 16'(rand_bits(16)));
        spi_write(A_PHY_RST, 16'(rand_bits(16)));
        for (int i = 0; i < TEST_WORDS; i++) spi_read(A_TEST_BASE + 7'(i));
        spi_read(A_PHY_RST);
        check_pins();
        for (int a = 0; a < 16; a++) begin
            if (a < 5 || a >= 8) spi_write(7'(a), 16'(rand_bits(16)));  // status words
        end
        spi_write(A_MDIO_I, 16'(rand_bits(16)));
        read_all();
        check_pins();

        // MDIO pin released before the DUT drives it
        spi_write(A_MDC, 16'h0001);
        check_pins();
        tb_mdio_en <= 1'b0;
        spi_write(A_MDIO_O, 16'h0001);
        spi_write(A_MDIO_OE, 16'h0001);
        check_pins();
        spi_read(A_MDIO_I);
        spi_write(A_MDIO_O, 16'h0000);
        check_pins();
        spi_read(A_MDIO_I);
        spi_write(A_MDIO_OE, 16'h0000);
        for (int i = 1; i >= 0; i--) begin
            tb_mdio_en  <= 1'b1;
            tb_mdio_val <= 1'(i);
            m_tb_mdio    = 1'(i);
            spi_read(A_MDIO_I);
        end
        spi_write(A_MDC, 16'h0000);
        check_pins();

        // CRC error pulses on all ports at once
        for (int p = 0; p < ETH_COUNT; p++) n[p] = int'(rand_bits(5));
        for (int k = 0; k < 32; k++) begin
            for (int p = 0; p < ETH_COUNT; p++) eth_crc_err[p] <= (k < n[p]);
            @(posedge clk125M);
        end
        eth_crc_err <= '0;
        for (int p = 0; p < ETH_COUNT; p++) m_err_cnt[p] = m_err_cnt[p] + 32'(n[p]);
        wait_cycles(2);
        for (int a = 0; a < 2 * ETH_COUNT; a++) spi_read(A_RXERR_BASE + 7'(a));
        repeat (2) begin
            v = ETH_COUNT'(rand_bits(ETH_COUNT));
            eth_link <= v;
            m_link    = v;
            spi_read(A_LINK);
        end

        check_flash_path();
        check_led();

        wait_cycles(4);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/tb_clk_gen.sv
// testbench clock and reset source for the board control testbench
// reset is held low for a fixed number of clock cycles
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;    // released on a rising edge
    end

endmodule

//--- src/board_ctrl_top.sv
// board control top, SPI register access, PHY management pins and heartbeat LED
// user SPI is shared with the config flash, CS0 goes to the flash, CS1 to the registers
`timescale 1ns/1ps

module board_ctrl_top #(
    parameter int          ETH_COUNT  = 4,
    parameter int          CLK_PER_US = 125,
    parameter int          US_PER_MS  = 1000,
    parameter int          BLINK_MS   = 250,
    parameter logic [31:0] FW_DATE    = 32'h0,
    parameter logic [31:0] FW_TIME    = 32'h0
) (
    input  logic                 clk125M,
    input  logic                 rst_n_i,
    // user SPI port
    input  logic                 usr_spi_clk_i,
    input  logic [1:0]           usr_spi_cs_i,
    input  logic                 usr_spi_mosi_i,
    output logic                 usr_spi_miso_o,
    // config flash
    output logic                 qspi_cs_o,
    output logic                 qspi_mosi_o,
    input  logic                 qspi_miso_i,
    // ethernet status and PHY management
    input  logic [ETH_COUNT-1:0] eth_link_i,
    input  logic [ETH_COUNT-1:0] eth_crc_err_i,
    output logic [ETH_COUNT-1:0] eth_phy_rst_o,
    output logic                 eth_phy_mdc_o,
    inout  wire                  eth_phy_mdio,
    output logic                 dbg_led_o
);
    import board_pkg::*;
    import regmap_pkg::*;

    if (ETH_COUNT < 1 || ETH_COUNT > ETH_PORTS_MAX) begin : g_bad_count
        $error("ETH_COUNT must be 1 to %0d", ETH_PORTS_MAX);
    end

    reg_wr_t                 reg_wr;
    logic [REG_AW-1:0]       rd_addr;
    logic [REG_DW-1:0]       rd_data;
    logic                    reg_miso;
    phy_mgmt_t               phy_mgmt;
    logic [ETH_COUNT*32-1:0] rx_err_cnt;

    spi_reg_slave u_spi (
        .clk125M    (clk125M),
        .rst_n_i    (rst_n_i),
        .spi_clk_i  (usr_spi_clk_i),
        .spi_cs_n_i (usr_spi_cs_i[1]),
        .spi_mosi_i (usr_spi_mosi_i),
        .spi_miso_o (reg_miso),
        .reg_wr_o   (reg_wr),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data)
    );

    reg_bank #(
        .ETH_COUNT (ETH_COUNT),
        .FW_DATE   (FW_DATE),
        .FW_TIME   (FW_TIME)
    ) u_regs (
        .clk125M      (clk125M),
        .rst_n_i      (rst_n_i),
        .reg_wr_i     (reg_wr),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .link_i       (eth_link_i),
        .rx_err_cnt_i (rx_err_cnt),
        .mdio_i       (eth_phy_mdio),
        .phy_mgmt_o   (phy_mgmt)
    );

    rx_err_counters #(.ETH_COUNT(ETH_COUNT)) u_rxerr (
        .clk125M   (clk125M),
        .rst_n_i   (rst_n_i),
        .crc_err_i (eth_crc_err_i),
        .cnt_o     (rx_err_cnt)
    );

    led_heartbeat #(
        .CLK_PER_US (CLK_PER_US),
        .US_PER_MS  (US_PER_MS),
        .BLINK_MS   (BLINK_MS)
    ) u_led (
        .clk125M (clk125M),
        .rst_n_i (rst_n_i),
        .led_o   (dbg_led_o)
    );

    // ------------------------------
    // pins
    // ------------------------------
    assign eth_phy_rst_o = phy_mgmt.phy_rst[ETH_COUNT-1:0];
    assign eth_phy_mdc_o = phy_mgmt.mdc;
    assign eth_phy_mdio  = phy_mgmt.mdio_oe ? phy_mgmt.mdio_o : 1'bz;   // PHY drives when off

    assign qspi_cs_o   = usr_spi_cs_i[0];
    assign qspi_mosi_o = usr_spi_mosi_i;
    // a deselected slave forces its term high so the other one wins
    assign usr_spi_miso_o = (qspi_miso_i | usr_spi_cs_i[0]) & (reg_miso | usr_spi_cs_i[1]);

endmodule

//--- src/led_heartbeat.sv
// debug LED heartbeat from a us, ms and blink prescaler chain
`timescale 1ns/1ps

module led_heartbeat #(
    parameter int CLK_PER_US = 125,
    parameter int US_PER_MS  = 1000,
    parameter int BLINK_MS   = 250
) (
    input  logic clk125M,
    input  logic rst_n_i,
    output logic led_o
);

    localparam int DIV [3] = '{CLK_PER_US, US_PER_MS, BLINK_MS};
    localparam int DIV_MAX = (CLK_PER_US > US_PER_MS) ?
                             ((CLK_PER_US > BLINK_MS) ? CLK_PER_US : BLINK_MS) :
                             ((US_PER_MS > BLINK_MS) ? US_PER_MS : BLINK_MS);
    localparam int CW      = $clog2(DIV_MAX + 1);

    logic [CW-1:0] cnt_q [3];
    logic [3:0]    tick;    // 1: us, 2: ms, 3: toggle
    logic          led_q;

    assign tick[0] = 1'b1;  // every clock

    for (genvar s = 0; s < 3; s++) begin : g_stage
        assign tick[s+1] = tick[s] && (cnt_q[s] == CW'(DIV[s] - 1));

        always_ff @(posedge clk125M) begin
            if (!rst_n_i) begin
                cnt_q[s] <= '0;
            end else if (tick[s+1]) begin
                cnt_q[s] <= '0;
            end else if (tick[s]) begin
                cnt_q[s] <= cnt_q[s] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk125M) begin
        if (!rst_n_i) led_q <= 1'b0;
        else          led_q <= led_q ^ tick[3];
    end

    assign led_o = led_q;

endmodule

//--- src/rx_err_counters.sv
// receive CRC error counters, one per ethernet port
// each error pulse adds one, counters stick at all ones
`timescale 1ns/1ps

module rx_err_counters #(
    parameter int ETH_COUNT = 4
) (
    input  logic                    clk125M,
    input  logic                    rst_n_i,
    input  logic [ETH_COUNT-1:0]    crc_err_i,
    output logic [ETH_COUNT*32-1:0] cnt_o
);

    localparam int CNT_W = 32;

    for (genvar p = 0; p < ETH_COUNT; p++) begin : g_port
        logic [CNT_W-1:0] cnt_q;

        always_ff @(posedge clk125M) begin
            if (!rst_n_i) begin
                cnt_q <= '0;
            end else if (crc_err_i[p] && cnt_q != '1) begin   // saturate
                cnt_q <= cnt_q + 1'b1;
            end
        end

        assign cnt_o[p*CNT_W +: CNT_W] = cnt_q;

        // the host reads halves at different times, so a wrap would look like garbage
        a_no_decrease: assert property (@(posedge clk125M) disable iff (!rst_n_i)
            cnt_q >= $past(cnt_q));
    end

endmodule

//--- src/reg_bank.sv
// host visible register bank behind the SPI slave
// writable PHY management and scratch words, read mux over all status
`timescale 1ns/1ps

module reg_bank #(
    parameter int          ETH_COUNT = 4,
    parameter logic [31:0] FW_DATE   = 32'h0,
    parameter logic [31:0] FW_TIME   = 32'h0
) (
    input  logic                          clk125M,
    input  logic                          rst_n_i,
    input  regmap_pkg::reg_wr_t           reg_wr_i,
    input  logic [regmap_pkg::REG_AW-1:0] rd_addr_i,
    output logic [regmap_pkg::REG_DW-1:0] rd_data_o,
    input  logic [ETH_COUNT-1:0]          link_i,
    input  logic [ETH_COUNT*32-1:0]       rx_err_cnt_i,
    input  logic                          mdio_i,
    output board_pkg::phy_mgmt_t          phy_mgmt_o
);
    import board_pkg::*;
    import regmap_pkg::*;

    localparam int                     TW_AW     = $clog2(TEST_WORDS);
    localparam logic [ETH_PORTS_MAX-1:0] PORT_MASK = ETH_PORTS_MAX'((1 << ETH_COUNT) - 1);

    phy_mgmt_t         phy_q;
    logic [REG_DW-1:0] test_q [TEST_WORDS];
    logic [REG_AW-1:0] wr_rel, rd_test_rel, rd_err_rel;
    logic              wr_ro;

    assign wr_rel = reg_wr_i.addr - A_TEST_BASE;

    // ------------------------------
    // write decode
    // ------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            phy_q <= '0;
            for (int i = 0; i < TEST_WORDS; i++) begin
                test_q[i] <= '0;
            end
        end else if (reg_wr_i.en) begin
            case (reg_wr_i.addr)
                A_PHY_RST: phy_q.phy_rst <= reg_wr_i.data[ETH_PORTS_MAX-1:0] & PORT_MASK;
                A_MDC:     phy_q.mdc     <= reg_wr_i.data[0];
                A_MDIO_O:  phy_q.mdio_o  <= reg_wr_i.data[0];
                A_MDIO_OE: phy_q.mdio_oe <= reg_wr_i.data[0];
                default: begin
                    if (reg_wr_i.addr >= A_TEST_BASE && wr_rel < REG_AW'(TEST_WORDS)) begin
                        test_q[wr_rel[TW_AW-1:0]] <= reg_wr_i.data;
                    end
                end
            endcase
        end
    end

    assign phy_mgmt_o = phy_q;

    // ------------------------------
    // read mux
    // ------------------------------
    assign rd_test_rel = rd_addr_i - A_TEST_BASE;
    assign rd_err_rel  = rd_addr_i - A_RXERR_BASE;     // 16 bit word index into counters

    always_comb begin
        rd_data_o = '0;     // unmapped reads as zero
        case (rd_addr_i)
            A_FW_DATE_LO: rd_data_o = FW_DATE[15:0];
            A_FW_DATE_HI: rd_data_o = FW_DATE[31:16];
            A_FW_TIME_LO: rd_data_o = FW_TIME[15:0];
            A_FW_TIME_HI: rd_data_o = FW_TIME[31:16];
            A_LINK:       rd_data_o = REG_DW'(link_i);
            A_PHY_RST:    rd_data_o = REG_DW'(phy_q.phy_rst);
            A_MDC:        rd_data_o = REG_DW'(phy_q.mdc);
            A_MDIO_O:     rd_data_o = REG_DW'(phy_q.mdio_o);
            A_MDIO_OE:    rd_data_o = REG_DW'(phy_q.mdio_oe);
            A_MDIO_I:     rd_data_o = REG_DW'(mdio_i);
            default: begin
                // absent ports fall outside 2*ETH_COUNT and read zero
                if (rd_addr_i >= A_RXERR_BASE && rd_err_rel < REG_AW'(2 * ETH_COUNT)) begin
                    rd_data_o = rx_err_cnt_i[rd_err_rel*REG_DW +: REG_DW];
                end
                if (rd_addr_i >= A_TEST_BASE && rd_test_rel < REG_AW'(TEST_WORDS)) begin
                    rd_data_o = test_q[rd_test_rel[TW_AW-1:0]];
                end
            end
        endcase
    end

    // status addresses, the whole counter window included
    assign wr_ro = (reg_wr_i.addr <= A_LINK) || (reg_wr_i.addr == A_MDIO_I) ||
                   (reg_wr_i.addr >= A_RXERR_BASE &&
                    reg_wr_i.addr < A_RXERR_BASE + REG_AW'(2 * ETH_PORTS_MAX));

    a_ro_write_no_effect: assert property (@(posedge clk125M) disable iff (!rst_n_i)
        (reg_wr_i.en && wr_ro) |=> $stable(phy_mgmt_o));

endmodule

//--- src/spi_reg_slave.sv
// SPI mode 0 register slave, command byte then 16 data bits, MSB first
// pins are sampled in the clk125M domain, SCLK must stay slow against clk125M
`timescale 1ns/1ps

module spi_reg_slave (
    input  logic                          clk125M,
    input  logic                          rst_n_i,
    input  logic                          spi_clk_i,
    input  logic                          spi_cs_n_i,
    input  logic                          spi_mosi_i,
    output logic                          spi_miso_o,
    output regmap_pkg::reg_wr_t           reg_wr_o,
    output logic [regmap_pkg::REG_AW-1:0] rd_addr_o,
    input  logic [regmap_pkg::REG_DW-1:0] rd_data_i
);
    import board_pkg::*;
    import regmap_pkg::*;

    localparam int CMD_BITS   = 8;
    localparam int FRAME_BITS = CMD_BITS + REG_DW;
    localparam int CNT_W      = $clog2(FRAME_BITS + 1);

    logic [1:0]          sclk_s, cs_s, mosi_s;  // two flop synchronizers
    logic                sclk_d;
    logic                rise_q, fall_q, mosi_q, cs_q;
    spi_state_e          state;
    logic [CNT_W-1:0]    bit_cnt;               // SCLK rises in the frame
    logic [CMD_BITS-2:0] cmd_sr;
    logic [REG_AW-1:0]   addr_q;
    logic [REG_DW-1:0]   data_sr;
    logic                ld_rd;
    logic                miso_q;
    logic                wr_en;
    logic [REG_AW-1:0]   wr_addr;
    logic [REG_DW-1:0]   wr_data;

    // ------------------------------
    // pin sync and edge detect
    // ------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            sclk_s <= '0;
            cs_s   <= '1;
            mosi_s <= '0;
            sclk_d <= 1'b0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            mosi_q <= 1'b0;
            cs_q   <= 1'b1;
        end else begin
            sclk_s <= {sclk_s[0], spi_clk_i};
            cs_s   <= {cs_s[0], spi_cs_n_i};
            mosi_s <= {mosi_s[0], spi_mosi_i};
            sclk_d <= sclk_s[1];
            rise_q <= sclk_s[1] & ~sclk_d;  // registered, one cycle behind the sync
            fall_q <= ~sclk_s[1] & sclk_d;
            mosi_q <= mosi_s[1];            // kept aligned with rise_q
            cs_q   <= cs_s[1];
        end
    end

    // ------------------------------
    // frame FSM
    // ------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            ld_rd   <= 1'b0;
            miso_q  <= 1'b0;
            wr_en   <= 1'b0;
        end else begin
            ld_rd <= 1'b0;
            wr_en <= 1'b0;
            if (cs_q) begin
                state <= ST_IDLE;   // CS high aborts whatever was going on
            end else begin
                case (state)
                    ST_IDLE: begin
                        state   <= ST_CMD;
                        bit_cnt <= '0;
                    end
                    ST_CMD: if (rise_q) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == CNT_W'(CMD_BITS - 1)) begin
                            if (spi_op_e'(cmd_sr[CMD_BITS-2]) == OP_WRITE) begin
                                state <= ST_DATA_WR;
                            end else begin
                                state <= ST_DATA_RD;
                                ld_rd <= 1'b1;      // fetch once, addr_q is valid now
                            end
                        end
                    end
                    ST_DATA_WR: if (rise_q && bit_cnt != CNT_W'(FRAME_BITS)) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        wr_en   <= (bit_cnt == CNT_W'(FRAME_BITS - 1));
                    end
                    ST_DATA_RD: if (fall_q) begin
                        miso_q <= data_sr[REG_DW-1];
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // shift registers and write payload
    always_ff @(posedge clk125M) begin
        if (state == ST_CMD && rise_q) begin
            cmd_sr <= {cmd_sr[CMD_BITS-3:0], mosi_q};
            if (bit_cnt == CNT_W'(CMD_BITS - 1)) begin
                addr_q <= {cmd_sr[CMD_BITS-3:0], mosi_q};
            end
        end
        if (ld_rd) begin
            data_sr <= rd_data_i;
        end else if (state == ST_DATA_RD && fall_q) begin
            data_sr <= {data_sr[REG_DW-2:0], 1'b0};
        end else if (state == ST_DATA_WR && rise_q) begin
            data_sr <= {data_sr[REG_DW-2:0], mosi_q};
        end
        if (state == ST_DATA_WR && rise_q && bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
            wr_addr <= addr_q;
            wr_data <= {data_sr[REG_DW-2:0], mosi_q};
        end
    end

    assign reg_wr_o.en   = wr_en;
    assign reg_wr_o.addr = wr_addr;
    assign reg_wr_o.data = wr_data;
    assign rd_addr_o     = addr_q;
    assign spi_miso_o    = miso_q;

    // the host keeps CS low for a half period after the last rise, longer than the pipe
    a_wr_inside_frame: assert property (@(posedge clk125M) disable iff (!rst_n_i)
        !(wr_en && spi_cs_n_i));
    a_wr_single_cycle: assert property (@(posedge clk125M) disable iff (!rst_n_i)
        wr_en |=> !wr_en);

endmodule

//--- src/regmap_pkg.sv
// register map of the board control bank seen through the user SPI port
// one address space for reads and writes

package regmap_pkg;

    localparam int REG_DW = 16;     // register width
    localparam int REG_AW = 7;      // address bits of the command byte

    // one register write, en is a single cycle strobe
    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
    } reg_wr_t;

    // ------------------------------
    // read only
    // ------------------------------
    localparam logic [REG_AW-1:0] A_FW_DATE_LO = 7'h00;
    localparam logic [REG_AW-1:0] A_FW_DATE_HI = 7'h01;
    localparam logic [REG_AW-1:0] A_FW_TIME_LO = 7'h02;
    localparam logic [REG_AW-1:0] A_FW_TIME_HI = 7'h03;
    localparam logic [REG_AW-1:0] A_LINK       = 7'h04;   // link bit per port
    // port n low half at base + 2n, high half at base + 2n + 1
    localparam logic [REG_AW-1:0] A_RXERR_BASE = 7'h08;

    // ------------------------------
    // PHY management
    // ------------------------------
    localparam logic [REG_AW-1:0] A_PHY_RST    = 7'h10;
    localparam logic [REG_AW-1:0] A_MDC        = 7'h11;
    localparam logic [REG_AW-1:0] A_MDIO_O     = 7'h12;
    localparam logic [REG_AW-1:0] A_MDIO_OE    = 7'h13;
    localparam logic [REG_AW-1:0] A_MDIO_I     = 7'h14;   // pin level, read only

    // scratch words for host access tests
    localparam logic [REG_AW-1:0] A_TEST_BASE  = 7'h20;
    localparam int                TEST_WORDS   = 4;

endpackage

//--- src/board_pkg.sv
// board level types shared by the SPI slave, the register bank and the top level
// port limits, PHY management levels and SPI slave enums

package board_pkg;

    // ------------------------------
    // ethernet ports
    // ------------------------------
    localparam int ETH_PORTS_MAX = 4;   // hard limit of the board

    // PHY management pin levels, as driven from the register bank
    typedef struct packed {
        logic [ETH_PORTS_MAX-1:0] phy_rst;  // one reset line per port
        logic                     mdc;      // bit-banged MDIO clock
        logic                     mdio_o;   // data level towards the PHY
        logic                     mdio_oe;  // 1 drives the MDIO pin
    } phy_mgmt_t;

    // ------------------------------
    // user SPI slave
    // ------------------------------
    // opcode sits in bit 7 of the command byte
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } spi_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,        // CS high, waiting for a frame
        ST_CMD,         // shifting in the command byte
        ST_DATA_WR,     // shifting in write data
        ST_DATA_RD      // shifting out read data
    } spi_state_e;

endpackage
